// ==== periph_soc.f ====
hdl/periph_pkg.sv
hdl/periph_fabric.sv
hdl/devtbl.sv
hdl/gpio_port.sv
hdl/intctrl.sv
hdl/rst_sequencer.sv
hdl/periph_soc.sv
testbench/periph_soc_properties.sv
testbench/periph_soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=periph_soc_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module periph_soc_tb --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
	-f periph_soc.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit "$status"
fi

"./$BUILD_DIR/$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit "$status"
fi
exit 0

// ==== testbench/periph_soc_tb.sv ====
// Peripheral subsystem testbench
module periph_soc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import periph_pkg::*;

	// The full run takes under 400 cycles.
	localparam int TIMEOUT_CYCLES = 2000;

	logic        clk100mhz;
	logic        rst_p;
	bus_req_t    req;
	bus_rsp_t    rsp;
	logic        credit;
	gpio_vec_t   gpio_in;
	gpio_vec_t   gpio_out;
	logic        ext_irq;
	logic        irq;

	logic [31:0] rng_state;
	int          credits;
	int          cycle_count;
	word_t       exp_q[$];
	string       name_q[$];
	gpio_vec_t   model_gpio_out;
	gpio_vec_t   model_gpio_in;
	irq_vec_t    model_pending;
	irq_vec_t    model_enable;

	periph_soc dut_i (
		.clk100mhz_i (clk100mhz),
		.rst_p       (rst_p),
		.req_i       (req),
		.rsp_o       (rsp),
		.credit_o    (credit),
		.gpio_i      (gpio_in),
		.gpio_o      (gpio_out),
		.ext_irq_i   (ext_irq),
		.irq_o       (irq)
	);

	initial begin
		clk100mhz = 1'b0;
		forever #5 clk100mhz = ~clk100mhz;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_gpio(input string name, input gpio_vec_t exp, input gpio_vec_t act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
		end
	endtask

	task automatic check_irq(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
		end
	endtask

	function automatic word_t next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic word_addr_t slot_addr(input slot_t slot, input word_off_t off);
		return word_addr_t'(slot) * word_addr_t'(SLOT_WORDS) + word_addr_t'(off);
	endfunction

	// Lands anywhere from the end of the map up to the top of the word space.
	function automatic word_addr_t unmapped_addr(input word_t seed);
		return MAP_END_WORD + word_addr_t'(seed % 32'h3fff_ff00);
	endfunction

	function automatic word_t mask_bytes(input word_t data, input byte_sel_t sel);
		word_t result;
		for (int b = 0; b < 4; b++) begin
			result[8*b +: 8] = sel[b] ? data[8*b +: 8] : 8'h00;
		end
		return result;
	endfunction

	function automatic word_t table_entry(input word_off_t idx);
		case (idx)
			4'd0:    return {DEV_USES_IRQ_OTHERS, 15'd0, DEV_ID_DEVTBL};
			4'd1:    return {DEV_USES_IRQ_GPIO, 15'd0, DEV_ID_GPIO};
			4'd2:    return {DEV_USES_IRQ_OTHERS, 15'd0, DEV_ID_INTCTRL};
			default: return '0;
		endcase
	endfunction

	// Expected response data from the register model and the address map.
	function automatic word_t expected_read(input bus_req_t r);
		word_off_t off;
		word_t     result;
		off    = word_off_t'(r.addr % word_addr_t'(SLOT_WORDS));
		result = '0;
		if (r.op == OP_READ && r.addr < MAP_END_WORD) begin
			case (slot_t'(r.addr / word_addr_t'(SLOT_WORDS)))
				SLOT_DEVTBL: result = table_entry(off);
				SLOT_GPIO: begin
					if (off == 4'd0) begin
						result = word_t'(model_gpio_in);
					end else if (off == 4'd1) begin
						result = word_t'(model_gpio_out);
					end
				end
				SLOT_INTCTRL: begin
					if (off == 4'd0) begin
						result = word_t'(model_pending);
					end else if (off == 4'd1) begin
						result = word_t'(model_enable);
					end
				end
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	task automatic model_write(input bus_req_t r);
		word_t data;
		data = mask_bytes(r.data, r.sel);
		if (r.op == OP_WRITE && r.addr == slot_addr(SLOT_GPIO, 4'd0)) begin
			model_gpio_out = data[GPIO_COUNT-1:0];
		end
		if (r.op == OP_WRITE && r.addr == slot_addr(SLOT_INTCTRL, 4'd0)) begin
			model_pending = model_pending & ~data[IRQ_SRC_COUNT-1:0];
		end
		if (r.op == OP_WRITE && r.addr == slot_addr(SLOT_INTCTRL, 4'd1)) begin
			model_enable = data[IRQ_SRC_COUNT-1:0];
		end
	endtask

	// One clock, ending on a falling edge, with returned credits counted.
	task automatic tick();
		@(negedge clk100mhz);
		req.op = OP_NONE;
		if (credit === 1'b1) begin
			credits = credits + 1;
		end
	endtask

	task automatic issue(input string name, input bus_op_t op, input word_addr_t addr,
		input word_t data, input byte_sel_t sel);
		bus_req_t r;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.sel  = sel;
		while (credits == 0) begin
			tick();
		end
		req     = r;
		credits = credits - 1;
		exp_q.push_back(expected_read(r));
		name_q.push_back(name);
		model_write(r);
		tick();
	endtask

	task automatic drain();
		while (credits != CREDIT_COUNT) begin
			tick();
		end
		repeat (3) tick();
	endtask

	task automatic read_device_table();
		for (int k = 0; k < SLOT_COUNT; k++) begin
			issue("devtbl entry", OP_READ, slot_addr(SLOT_DEVTBL, word_off_t'(k)), '0, 4'hf);
		end
		issue("devtbl empty word", OP_READ, slot_addr(SLOT_DEVTBL, 4'd5), '0, 4'hf);
		drain();
	endtask

	task automatic exercise_gpio();
		word_t     wdata;
		byte_sel_t wsel;
		gpio_vec_t pins;
		for (int i = 0; i < 4; i++) begin
			wdata = next_rand();
			wsel  = byte_sel_t'(next_rand());
			issue("gpio write", OP_WRITE, slot_addr(SLOT_GPIO, 4'd0), wdata, wsel);
			issue("gpio out readback", OP_READ, slot_addr(SLOT_GPIO, 4'd1), '0, 4'hf);
			drain();
			check_gpio("gpio_o after write", model_gpio_out, gpio_out);
			pins = gpio_vec_t'(next_rand());
			if (pins != model_gpio_in) begin
				model_pending[IRQ_SRC_GPIO] = 1'b1;
			end
			gpio_in       = pins;
			model_gpio_in = pins;
			repeat (4) tick();
			issue("gpio input read", OP_READ, slot_addr(SLOT_GPIO, 4'd0), '0, 4'hf);
		end
		drain();
	endtask

	task automatic exercise_interrupts();
		issue("irq mask off", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd1), '0, 4'hf);
		issue("irq ack all", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd0), 32'h3, 4'hf);
		issue("pending cleared", OP_READ, slot_addr(SLOT_INTCTRL, 4'd0), '0, 4'hf);
		drain();
		check_irq("irq idle", 1'b0, irq);
		gpio_in       = gpio_in ^ gpio_vec_t'(1);
		model_gpio_in = gpio_in;
		model_pending[IRQ_SRC_GPIO] = 1'b1;
		repeat (6) tick();
		issue("gpio pending", OP_READ, slot_addr(SLOT_INTCTRL, 4'd0), '0, 4'hf);
		drain();
		check_irq("irq masked", 1'b0, irq);
		issue("enable gpio", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd1), 32'h1, 4'hf);
		issue("enable readback", OP_READ, slot_addr(SLOT_INTCTRL, 4'd1), '0, 4'hf);
		drain();
		check_irq("irq from gpio", 1'b1, irq);
		ext_irq = 1'b1;
		repeat (2) tick();
		ext_irq = 1'b0;
		repeat (6) tick();
		model_pending[IRQ_SRC_EXT] = 1'b1;
		issue("both pending", OP_READ, slot_addr(SLOT_INTCTRL, 4'd0), '0, 4'hf);
		issue("enable ext only", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd1), 32'h2, 4'hf);
		issue("ack gpio", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd0), 32'h1, 4'hf);
		drain();
		check_irq("irq from ext", 1'b1, irq);
		issue("ack ext", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd0), 32'h2, 4'hf);
		issue("pending empty", OP_READ, slot_addr(SLOT_INTCTRL, 4'd0), '0, 4'hf);
		drain();
		check_irq("irq after ack", 1'b0, irq);
	endtask

	task automatic probe_unmapped();
		for (int i = 0; i < 6; i++) begin
			issue("unmapped read", OP_READ, unmapped_addr(next_rand()), '0, 4'hf);
			issue("unmapped write", OP_WRITE, unmapped_addr(next_rand()), 32'hdead_beef, 4'hf);
		end
		drain();
	endtask

	// Mixed slots, issued as fast as credits allow.
	task automatic run_traffic();
		word_t pick;
		word_t wdata;
		for (int i = 0; i < 24; i++) begin
			pick  = next_rand() % 32'd5;
			wdata = next_rand();
			case (pick)
				32'd0: issue("traffic devtbl", OP_READ,
					slot_addr(SLOT_DEVTBL, word_off_t'(wdata % 32'd4)), '0, 4'hf);
				32'd1: issue("traffic gpio write", OP_WRITE, slot_addr(SLOT_GPIO, 4'd0), wdata, 4'hf);
				32'd2: issue("traffic gpio read", OP_READ, slot_addr(SLOT_GPIO, 4'd1), '0, 4'hf);
				32'd3: issue("traffic mask read", OP_READ, slot_addr(SLOT_INTCTRL, 4'd1), '0, 4'hf);
				default: issue("traffic unmapped", OP_READ, unmapped_addr(wdata), '0, 4'hf);
			endcase
		end
		drain();
		check_gpio("gpio_o after traffic", model_gpio_out, gpio_out);
	endtask

	task automatic apply_warm_reset();
		issue("gpio preset", OP_WRITE, slot_addr(SLOT_GPIO, 4'd0), 32'h0000_00a5, 4'hf);
		issue("mask preset", OP_WRITE, slot_addr(SLOT_INTCTRL, 4'd1), 32'h3, 4'hf);
		drain();
		check_gpio("gpio_o preset", model_gpio_out, gpio_out);
		issue("warm reset", OP_WRITE, slot_addr(SLOT_DEVTBL, DEVTBL_RST_WORD), RST_WARM_KEY, 4'hf);
		drain();
		repeat (RST_HOLD_CYCLES + 4) tick();
		model_gpio_out = '0;
		model_enable   = '0;
		check_gpio("gpio_o after warm reset", model_gpio_out, gpio_out);
		check_irq("irq after warm reset", 1'b0, irq);
		issue("mask after warm reset", OP_READ, slot_addr(SLOT_INTCTRL, 4'd1), '0, 4'hf);
		read_device_table();
	endtask

	// Responses come back in request order.
	always @(negedge clk100mhz) begin
		if (rst_p === 1'b0 && rsp.valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				abort_run("A response arrived with no request outstanding");
			end else begin
				check_word(name_q.pop_front(), exp_q.pop_front(), rsp.data);
			end
		end
	end

	always @(posedge clk100mhz) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: run did not finish in %0d cycles", TIMEOUT_CYCLES));
		end
	end

	initial begin
		rng_state      = 32'h45e2;
		credits        = CREDIT_COUNT;
		cycle_count    = 0;
		model_gpio_out = '0;
		model_gpio_in  = '0;
		model_pending  = '0;
		model_enable   = '0;
		req            = '0;
		gpio_in        = '0;
		ext_irq        = 1'b0;
		rst_p          = 1'b1;
		repeat (10) tick();
		rst_p = 1'b0;
		// Peripherals stay in reset for the hold count.
		repeat (RST_HOLD_CYCLES + 4) tick();
		read_device_table();
		exercise_gpio();
		exercise_interrupts();
		probe_unmapped();
		run_traffic();
		apply_warm_reset();
		if (exp_q.size() != 0) begin
			abort_run("Responses were still missing at the end of the run");
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

// ==== testbench/periph_soc_properties.sv ====
// Fabric credit and response checks
module periph_soc_properties (
	input logic                 clk100mhz_i,
	input logic                 rst_p,
	input periph_pkg::bus_req_t req_i,
	input periph_pkg::bus_rsp_t rsp_i,
	input logic                 credit_i
);
	timeunit 1ns;
	timeprecision 1ps;
	import periph_pkg::*;

	int   held;
	logic req_seen;

	assign req_seen = (req_i.op != OP_NONE);

	// Credits the master holds, as seen from the fabric.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			held <= CREDIT_COUNT;
		end else begin
			held <= held + (credit_i ? 1 : 0) - (req_seen ? 1 : 0);
		end
	end

	// A credit returned in this cycle may be spent in the same cycle.
	credit_available: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		req_seen |-> (held + (credit_i ? 1 : 0) > 0))
		else $error("Request issued while the master held no credit");

	credit_with_rsp: assert property (@(posedge clk100mhz_i) disable iff (rst_p)
		credit_i |-> (rsp_i.valid && held < CREDIT_COUNT))
		else $error("Credit returned without a response to an outstanding request");

	rsp_quiet_in_reset: assert property (@(posedge clk100mhz_i)
		rst_p |=> !rsp_i.valid)
		else $error("Response valid while the fabric was in reset");

endmodule

bind periph_fabric periph_soc_properties props_i (
	.clk100mhz_i (clk100mhz_i),
	.rst_p       (rst_p),
	.req_i       (req_i),
	.rsp_i       (rsp_o),
	.credit_i    (credit_o)
);

// ==== hdl/periph_soc.sv ====
// Peripheral subsystem top level
module periph_soc (
	input  logic                  clk100mhz_i,
	input  logic                  rst_p,
	input  periph_pkg::bus_req_t  req_i,
	output periph_pkg::bus_rsp_t  rsp_o,
	output logic                  credit_o,
	input  periph_pkg::gpio_vec_t gpio_i,
	output periph_pkg::gpio_vec_t gpio_o,
	input  logic                  ext_irq_i,
	output logic                  irq_o
);
	import periph_pkg::*;

	dev_req_t devtbl_req;
	dev_req_t gpio_req;
	dev_req_t intctrl_req;
	word_t    devtbl_rdata;
	word_t    gpio_rdata;
	word_t    intctrl_rdata;
	logic     warm_rst;
	logic     periph_rst;
	logic     gpio_change;
	irq_vec_t irq_src;

	assign irq_src[IRQ_SRC_GPIO] = gpio_change;
	assign irq_src[IRQ_SRC_EXT]  = ext_irq_i;

	periph_fabric fabric_i (
		.clk100mhz_i     (clk100mhz_i),
		.rst_p           (rst_p),
		.req_i           (req_i),
		.rsp_o           (rsp_o),
		.credit_o        (credit_o),
		.devtbl_req_o    (devtbl_req),
		.gpio_req_o      (gpio_req),
		.intctrl_req_o   (intctrl_req),
		.devtbl_rdata_i  (devtbl_rdata),
		.gpio_rdata_i    (gpio_rdata),
		.intctrl_rdata_i (intctrl_rdata)
	);

	devtbl devtbl_i (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.dev_req_i   (devtbl_req),
		.rdata_o     (devtbl_rdata),
		.warm_rst_o  (warm_rst)
	);

	gpio_port gpio_i0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_i       (periph_rst),
		.dev_req_i   (gpio_req),
		.rdata_o     (gpio_rdata),
		.gpio_i      (gpio_i),
		.gpio_o      (gpio_o),
		.change_o    (gpio_change)
	);

	intctrl intctrl_i (
		.clk100mhz_i (clk100mhz_i),
		.rst_i       (periph_rst),
		.dev_req_i   (intctrl_req),
		.rdata_o     (intctrl_rdata),
		.src_i       (irq_src),
		.irq_o       (irq_o)
	);

	rst_sequencer rst_seq_i (
		.clk100mhz_i  (clk100mhz_i),
		.rst_p        (rst_p),
		.warm_rst_i   (warm_rst),
		.periph_rst_o (periph_rst)
	);

endmodule

// ==== hdl/rst_sequencer.sv ====
// Peripheral reset sequencer
module rst_sequencer (
	input  logic clk100mhz_i,
	input  logic rst_p,
	input  logic warm_rst_i,
	output logic periph_rst_o
);
	import periph_pkg::*;

	rst_cnt_t hold_cnt;

	// Reload on either reset source, then drain to zero.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || warm_rst_i) begin
			hold_cnt <= rst_cnt_t'(RST_HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	assign periph_rst_o = (hold_cnt != '0);

endmodule

// ==== hdl/intctrl.sv ====
// Interrupt controller
module intctrl (
	input  logic                 clk100mhz_i,
	input  logic                 rst_i,
	input  periph_pkg::dev_req_t dev_req_i,
	output periph_pkg::word_t    rdata_o,
	input  periph_pkg::irq_vec_t src_i,
	output logic                 irq_o
);
	import periph_pkg::*;

	logic     ext_meta;
	logic     ext_sync;
	logic     ext_prev;
	irq_vec_t src_set;
	irq_vec_t pending;
	irq_vec_t enable;
	irq_vec_t ack;
	logic     wr_en_word;

	// External line is asynchronous, only its rising edge counts.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_i) begin
			ext_meta <= 1'b0;
			ext_sync <= 1'b0;
			ext_prev <= 1'b0;
		end else begin
			ext_meta <= src_i[IRQ_SRC_EXT];
			ext_sync <= ext_meta;
			ext_prev <= ext_sync;
		end
	end

	always_comb begin
		src_set               = '0;
		src_set[IRQ_SRC_GPIO] = src_i[IRQ_SRC_GPIO];
		src_set[IRQ_SRC_EXT]  = ext_sync && !ext_prev;
		ack = '0;
		if (dev_req_i.strobe && dev_req_i.write && (dev_req_i.offset == 4'd0)) begin
			ack = dev_req_i.data[IRQ_SRC_COUNT-1:0];
		end
	end

	assign wr_en_word = dev_req_i.strobe && dev_req_i.write && (dev_req_i.offset == 4'd1);

	// A new event in the same cycle as its acknowledge stays pending.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_i) begin
			pending <= '0;
			enable  <= '0;
			irq_o   <= 1'b0;
		end else begin
			pending <= (pending & ~ack) | src_set;
			if (wr_en_word) begin
				enable <= dev_req_i.data[IRQ_SRC_COUNT-1:0];
			end
			irq_o <= |(pending & enable);
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (dev_req_i.strobe && !dev_req_i.write) begin
			case (dev_req_i.offset)
				4'd0:    rdata_o <= word_t'(pending);
				4'd1:    rdata_o <= word_t'(enable);
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/gpio_port.sv ====
// General purpose I/O port
module gpio_port (
	input  logic                  clk100mhz_i,
	input  logic                  rst_i,
	input  periph_pkg::dev_req_t  dev_req_i,
	output periph_pkg::word_t     rdata_o,
	input  periph_pkg::gpio_vec_t gpio_i,
	output periph_pkg::gpio_vec_t gpio_o,
	output logic                  change_o
);
	import periph_pkg::*;

	gpio_vec_t in_meta;
	gpio_vec_t in_sync;
	gpio_vec_t in_prev;
	logic      wr_data;

	assign wr_data = dev_req_i.strobe && dev_req_i.write && (dev_req_i.offset == 4'd0);

	// Two flop synchronizer, then compare against last sample.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_i) begin
			in_meta  <= '0;
			in_sync  <= '0;
			in_prev  <= '0;
			change_o <= 1'b0;
		end else begin
			in_meta  <= gpio_i;
			in_sync  <= in_meta;
			in_prev  <= in_sync;
			change_o <= (in_sync != in_prev);
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_i) begin
			gpio_o <= '0;
		end else if (wr_data) begin
			gpio_o <= dev_req_i.data[GPIO_COUNT-1:0];
		end
	end

	// Word 0 is the pin state, word 1 the output latch.
	always_ff @(posedge clk100mhz_i) begin
		if (dev_req_i.strobe && !dev_req_i.write) begin
			case (dev_req_i.offset)
				4'd0:    rdata_o <= word_t'(in_sync);
				4'd1:    rdata_o <= word_t'(gpio_o);
				default: rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== hdl/devtbl.sv ====
// Device table and warm reset
module devtbl (
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  periph_pkg::dev_req_t dev_req_i,
	output periph_pkg::word_t    rdata_o,
	output logic                 warm_rst_o
);
	import periph_pkg::*;

	word_t entry;
	logic  warm_hit;

	// One entry per mapped slot, interrupt use in the top bit.
	always_comb begin
		entry = '0;
		if (dev_req_i.offset < word_off_t'(SLOT_COUNT)) begin
			case (slot_t'(dev_req_i.offset))
				SLOT_DEVTBL:  entry = {DEV_USES_IRQ_OTHERS, 15'd0, DEV_ID_DEVTBL};
				SLOT_GPIO:    entry = {DEV_USES_IRQ_GPIO, 15'd0, DEV_ID_GPIO};
				SLOT_INTCTRL: entry = {DEV_USES_IRQ_OTHERS, 15'd0, DEV_ID_INTCTRL};
				default:      entry = '0;
			endcase
		end
	end

	assign warm_hit = dev_req_i.strobe && dev_req_i.write &&
		(dev_req_i.offset == DEVTBL_RST_WORD) && (dev_req_i.data == RST_WARM_KEY);

	always_ff @(posedge clk100mhz_i) begin
		if (dev_req_i.strobe && !dev_req_i.write) begin
			rdata_o <= entry;
		end
	end

	// Single cycle request to the reset sequencer.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			warm_rst_o <= 1'b0;
		end else begin
			warm_rst_o <= warm_hit;
		end
	end

endmodule

// ==== hdl/periph_fabric.sv ====
// Peripheral request fabric
module periph_fabric (
	input  logic                 clk100mhz_i,
	input  logic                 rst_p,
	input  periph_pkg::bus_req_t req_i,
	output periph_pkg::bus_rsp_t rsp_o,
	output logic                 credit_o,
	output periph_pkg::dev_req_t devtbl_req_o,
	output periph_pkg::dev_req_t gpio_req_o,
	output periph_pkg::dev_req_t intctrl_req_o,
	input  periph_pkg::word_t    devtbl_rdata_i,
	input  periph_pkg::word_t    gpio_rdata_i,
	input  periph_pkg::word_t    intctrl_rdata_i
);
	import periph_pkg::*;

	bus_req_t   queue_mem [CREDIT_COUNT];
	queue_ptr_t wr_ptr;
	queue_ptr_t rd_ptr;
	queue_cnt_t q_count;
	logic       push;
	logic       pop;
	bus_req_t   head;
	slot_t      head_slot;
	dev_req_t   head_dev;

	logic       disp_valid;
	slot_t      disp_slot;
	dev_req_t   disp_req;

	logic       infl_valid;
	logic       infl_write;
	slot_t      infl_slot;
	word_t      infl_rdata;

	function automatic queue_ptr_t ptr_next(input queue_ptr_t ptr);
		if (ptr == queue_ptr_t'(CREDIT_COUNT - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push = (req_i.op != OP_NONE);
	assign pop  = (q_count != '0);
	assign head = queue_mem[rd_ptr];

	// Slot decode and byte lane masking of the queue head.
	always_comb begin
		if (head.addr >= MAP_END_WORD) begin
			head_slot = SLOT_INVALID;
		end else begin
			head_slot = slot_t'(head.addr / SLOT_WORDS);
		end
		head_dev.strobe = (head_slot != SLOT_INVALID);
		head_dev.write  = (head.op == OP_WRITE);
		head_dev.offset = word_off_t'(head.addr % SLOT_WORDS);
		for (int b = 0; b < $bits(byte_sel_t); b++) begin
			head_dev.data[8*b +: 8] = head.sel[b] ? head.data[8*b +: 8] : 8'h00;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (push) begin
			queue_mem[wr_ptr] <= req_i;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			q_count    <= '0;
			disp_valid <= 1'b0;
			infl_valid <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			if (push && !pop) begin
				q_count <= q_count + 1'b1;
			end else if (pop && !push) begin
				q_count <= q_count - 1'b1;
			end
			disp_valid <= pop;
			infl_valid <= disp_valid;
		end
	end

	// Dispatch and in-flight payload.
	always_ff @(posedge clk100mhz_i) begin
		if (pop) begin
			disp_slot <= head_slot;
			disp_req  <= head_dev;
		end
		infl_slot  <= disp_slot;
		infl_write <= disp_req.write;
	end

	always_comb begin
		devtbl_req_o         = disp_req;
		devtbl_req_o.strobe  = disp_valid && (disp_slot == SLOT_DEVTBL);
		gpio_req_o           = disp_req;
		gpio_req_o.strobe    = disp_valid && (disp_slot == SLOT_GPIO);
		intctrl_req_o        = disp_req;
		intctrl_req_o.strobe = disp_valid && (disp_slot == SLOT_INTCTRL);
	end

	// Unmapped slot acts as default slave and reads zero.
	always_comb begin
		case (infl_slot)
			SLOT_DEVTBL:  infl_rdata = devtbl_rdata_i;
			SLOT_GPIO:    infl_rdata = gpio_rdata_i;
			SLOT_INTCTRL: infl_rdata = intctrl_rdata_i;
			default:      infl_rdata = '0;
		endcase
		rsp_o.valid = infl_valid;
		rsp_o.data  = infl_write ? '0 : infl_rdata;
	end

	assign credit_o = infl_valid;

endmodule

// ==== hdl/periph_pkg.sv ====
// Peripheral fabric definitions
package periph_pkg;

	// Sizes of the peripheral set.
	localparam int GPIO_COUNT      = 8;
	localparam int IRQ_SRC_COUNT   = 2;
	localparam int IRQ_SRC_GPIO    = 0;
	localparam int IRQ_SRC_EXT     = 1;
	localparam int SLOT_WORDS      = 16;
	localparam int SLOT_COUNT      = 3;
	localparam int CREDIT_COUNT    = 2;
	localparam int RST_HOLD_CYCLES = 16;

	localparam int QUEUE_PTR_W = $clog2(CREDIT_COUNT);
	localparam int QUEUE_CNT_W = $clog2(CREDIT_COUNT + 1);
	localparam int RST_CNT_W   = $clog2(RST_HOLD_CYCLES + 1);

	typedef logic [31:0]               word_t;
	typedef logic [29:0]               word_addr_t;
	typedef logic [3:0]                byte_sel_t;
	typedef logic [3:0]                word_off_t;
	typedef logic [15:0]               dev_id_t;
	typedef logic [GPIO_COUNT-1:0]     gpio_vec_t;
	typedef logic [IRQ_SRC_COUNT-1:0]  irq_vec_t;
	typedef logic [1:0]                slot_t;
	typedef logic [QUEUE_PTR_W-1:0]    queue_ptr_t;
	typedef logic [QUEUE_CNT_W-1:0]    queue_cnt_t;
	typedef logic [RST_CNT_W-1:0]      rst_cnt_t;

	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} bus_op_t;

	typedef struct packed {
		bus_op_t    op;
		word_addr_t addr;
		word_t      data;
		byte_sel_t  sel;
	} bus_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} bus_rsp_t;

	typedef struct packed {
		logic      strobe;
		logic      write;
		word_off_t offset;
		word_t     data;
	} dev_req_t;

	// Address map, one slot of SLOT_WORDS words per device.
	localparam slot_t      SLOT_DEVTBL  = 2'd0;
	localparam slot_t      SLOT_GPIO    = 2'd1;
	localparam slot_t      SLOT_INTCTRL = 2'd2;
	localparam slot_t      SLOT_INVALID = 2'd3;
	localparam word_addr_t MAP_END_WORD = word_addr_t'(SLOT_COUNT * SLOT_WORDS);

	// Device table contents.
	localparam dev_id_t DEV_ID_DEVTBL       = 16'd7;
	localparam dev_id_t DEV_ID_GPIO         = 16'd6;
	localparam dev_id_t DEV_ID_INTCTRL      = 16'd3;
	localparam logic    DEV_USES_IRQ_GPIO   = 1'b1;
	localparam logic    DEV_USES_IRQ_OTHERS = 1'b0;

	localparam word_off_t DEVTBL_RST_WORD = 4'd15;
	localparam word_t     RST_WARM_KEY    = 32'h0000_0002;

endpackage
